// File: source/encoder_pkg.sv
// Types shared by the encoder datapath blocks and the testbench.
// The angle width bounds max_count, so counts above 2^24-1 cannot be used.
// The speed is a signed net step count per window and must fit in 16 bits.
package encoder_pkg;

    // Wrapping angle count, compared against max_count for the wrap
    typedef logic [23:0] angle_t;

    // Net signed steps seen during one speed window
    // Positive values mean motion in the counting-up direction
    typedef logic signed [15:0] speed_t;

    // Count of illegal double transitions on a and b
    // It saturates at all ones and only reset clears it
    typedef logic [7:0] error_count_t;

    // Index zeroing progress
    // The first index edge only arms the zeroing logic
    // The second edge captures the zero value
    // Every later edge reloads the count with the captured zero value
    typedef enum logic [1:0] {
        seek_first,
        seek_second,
        locked
    } index_state_t;

endpackage

// File: source/stream_pkg.sv
// Types of the output record stream.
// The stream is valid-strobed only and has no ready or back-pressure.
package stream_pkg;

    // Routing word copied unchanged into every record
    typedef logic [31:0] destination_t;

    // Record payload, wide enough for an angle or a sign-extended speed
    typedef logic [31:0] record_data_t;

    // Record opcode telling the receiver how to read the payload
    // An angle record is always followed one cycle later by a speed record
    typedef enum logic {
        kind_angle,
        kind_speed
    } record_kind_t;

endpackage

// File: source/quadrature_filter.sv
// Synchronizes and debounces the raw a, b and z encoder inputs.
// A level must hold for filter_length samples after the two synchronizer
// flops before the clean output follows it. Shorter pulses are dropped.
// All clean levels come out of reset low.
module quadrature_filter #(
    parameter int filter_length = 4
) (
    input  logic clock,
    input  logic reset,
    input  logic a,
    input  logic b,
    input  logic z,
    output logic a_clean,
    output logic b_clean,
    output logic z_clean
);

    // Wide enough to hold filter_length - 1 for any filter_length of 1 or more
    localparam int run_width = $clog2(filter_length + 1);

    logic [2:0] raw;
    logic [2:0] sync_first;
    logic [2:0] sync_second;
    logic [2:0] clean;

    // Bit 0 is a, bit 1 is b and bit 2 is z
    assign raw = {z, b, a};

    // Two flop synchronizer for the asynchronous encoder pins
    always_ff @(posedge clock) begin
        if (reset) begin
            sync_first <= '0;
            sync_second <= '0;
        end else begin
            sync_first <= raw;
            sync_second <= sync_first;
        end
    end

    // One stability counter per input channel
    for (genvar i = 0; i < 3; i++) begin : channel
        logic [run_width-1:0] run;
        logic level;

        // The run counts consecutive samples that disagree with the clean level
        // Any sample that agrees again restarts the run
        always_ff @(posedge clock) begin
            if (reset) begin
                run <= '0;
                level <= 1'b0;
            end else if (sync_second[i] == level) begin
                run <= '0;
            end else if (run == run_width'(filter_length - 1)) begin
                // Enough equal samples seen, so the new level is accepted
                level <= sync_second[i];
                run <= '0;
            end else begin
                run <= run + 1'b1;
            end
        end

        assign clean[i] = level;
    end

    assign a_clean = clean[0];
    assign b_clean = clean[1];
    assign z_clean = clean[2];

endmodule

// File: source/quadrature_decoder.sv
// Decodes filtered quadrature levels into registered one-cycle pulses.
// Inputs must already be synchronous and glitch free.
// A change of a and b in the same cycle is illegal; it gives no step and
// bumps the saturating error count instead.
module quadrature_decoder (
    input  logic clock,
    input  logic reset,
    input  logic a_clean,
    input  logic b_clean,
    input  logic z_clean,
    output logic step,
    output logic direction,
    output logic index_rise,
    output encoder_pkg::error_count_t error_count
);

    logic a_prev;
    logic b_prev;
    logic z_prev;
    logic a_change;
    logic b_change;
    logic transition_error;

    assign a_change = a_clean ^ a_prev;
    assign b_change = b_clean ^ b_prev;

    always_ff @(posedge clock) begin
        if (reset) begin
            a_prev <= 1'b0;
            b_prev <= 1'b0;
            z_prev <= 1'b0;
            step <= 1'b0;
            direction <= 1'b0;
            index_rise <= 1'b0;
            transition_error <= 1'b0;
            error_count <= '0;
        end else begin
            a_prev <= a_clean;
            b_prev <= b_clean;
            z_prev <= z_clean;
            // Exactly one channel changed, which is a legal quadrature step
            step <= a_change ^ b_change;
            // Counting up when the new a differs from the old b
            direction <= a_clean ^ b_prev;
            index_rise <= z_clean & ~z_prev;
            // Both channels moving at once leaves the step direction unknown
            transition_error <= a_change & b_change;
            // Saturate rather than wrap so a high count stays visible
            if (transition_error && error_count != '1) begin
                error_count <= error_count + 1'b1;
            end
        end
    end

    // A double change of the filtered levels must never come out as a step
    assert property (@(posedge clock) disable iff (reset)
        (a_clean != $past(a_clean) && b_clean != $past(b_clean)) |=> !step)
        else $error("quadrature_decoder: step issued on an illegal transition");

endmodule

// File: source/position_counter.sv
// Wrapping up/down angle counter with index zero capture and reload.
// The count runs from 0 to max_count inclusive and wraps at both ends.
// A reload on the same cycle as a step wins, and that step is lost.
// Lowering max_count below the current angle resets the angle to 0.
module position_counter (
    input  logic clock,
    input  logic reset,
    input  logic step,
    input  logic direction,
    input  logic capture_zero,
    input  logic load_zero,
    input  encoder_pkg::angle_t max_count,
    output encoder_pkg::angle_t angle
);

    import encoder_pkg::*;

    angle_t zero_value;

    always_ff @(posedge clock) begin
        if (reset) begin
            angle <= '0;
        end else if (load_zero) begin
            // A zero value captured under a larger max_count is out of range now
            angle <= (zero_value > max_count) ? '0 : zero_value;
        end else if (angle > max_count) begin
            angle <= '0;
        end else if (step) begin
            if (direction) begin
                angle <= (angle == max_count) ? '0 : angle + 1'b1;
            end else begin
                angle <= (angle == '0) ? max_count : angle - 1'b1;
            end
        end
    end

    // Zero value taken from the angle on the second index edge
    always_ff @(posedge clock) begin
        if (capture_zero) begin
            zero_value <= angle;
        end
    end

    // With max_count held across a cycle the angle has had a chance to wrap
    // or clear, so it must sit inside the range
    assert property (@(posedge clock) disable iff (reset)
        $stable(max_count) |-> (angle <= max_count))
        else $error("position_counter: angle above max_count");

endmodule

// File: source/speed_estimator.sv
// Measures speed as the net signed step count over a fixed window.
// Windows are window_length cycles long and start at reset release.
// The accumulator wraps if more than 32767 net steps arrive in one window.
module speed_estimator #(
    parameter int window_length = 256
) (
    input  logic clock,
    input  logic reset,
    input  logic step,
    input  logic direction,
    output encoder_pkg::speed_t speed
);

    import encoder_pkg::*;

    localparam int timer_width = (window_length > 1) ? $clog2(window_length) : 1;

    logic [timer_width-1:0] timer;
    logic window_end;
    speed_t accumulator;
    speed_t delta;

    assign window_end = (timer == timer_width'(window_length - 1));

    // Signed contribution of this cycle's step
    always_comb begin
        if (!step) begin
            delta = '0;
        end else if (direction) begin
            delta = speed_t'(1);
        end else begin
            delta = speed_t'(-1);
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            timer <= '0;
            accumulator <= '0;
            speed <= '0;
        end else begin
            timer <= window_end ? '0 : timer + 1'b1;
            if (window_end) begin
                speed <= accumulator;
                // The step on the closing cycle belongs to the next window
                accumulator <= delta;
            end else begin
                accumulator <= accumulator + delta;
            end
        end
    end

endmodule

// File: source/index_control.sv
// Control for index zeroing and for the two-beat record sequence.
// Index edges must arrive as one-cycle pulses from the decoder.
// A sample gives an angle beat at once and a speed beat on the next cycle;
// a sample during the speed beat is ignored.
module index_control (
    input  logic clock,
    input  logic reset,
    input  logic index_rise,
    input  logic sample,
    output logic capture_zero,
    output logic load_zero,
    output encoder_pkg::index_state_t index_state,
    output logic emit,
    output stream_pkg::record_kind_t kind
);

    import encoder_pkg::*;
    import stream_pkg::*;

    typedef enum logic {
        beat_idle,
        beat_speed
    } beat_state_t;

    beat_state_t beat;

    // The index FSM advances only on rising index edges
    always_ff @(posedge clock) begin
        if (reset) begin
            index_state <= seek_first;
            capture_zero <= 1'b0;
            load_zero <= 1'b0;
        end else begin
            capture_zero <= 1'b0;
            load_zero <= 1'b0;
            if (index_rise) begin
                case (index_state)
                    seek_first: index_state <= seek_second;
                    seek_second: begin
                        index_state <= locked;
                        capture_zero <= 1'b1;
                    end
                    locked: load_zero <= 1'b1;
                    default: index_state <= seek_first;
                endcase
            end
        end
    end

    // The record sequencer issues the angle beat in the sample cycle itself
    always_ff @(posedge clock) begin
        if (reset) begin
            beat <= beat_idle;
        end else if (beat == beat_speed) begin
            beat <= beat_idle;
        end else if (sample) begin
            beat <= beat_speed;
        end
    end

    assign emit = sample || (beat == beat_speed);
    assign kind = (beat == beat_speed) ? kind_speed : kind_angle;

    // Each zero strobe follows its own index edge by one cycle, never both at once
    assert property (@(posedge clock) disable iff (reset)
        (capture_zero || load_zero) |-> ($past(index_rise) && !(capture_zero && load_zero)))
        else $error("index_control: zero capture and reload in the same cycle");

endmodule

// File: source/sample_output.sv
// Output register stage for angle and speed records.
// record_valid is a one-cycle strobe per record with no back-pressure, so
// the receiver must take every record on the cycle it is valid.
module sample_output (
    input  logic clock,
    input  logic reset,
    input  logic emit,
    input  stream_pkg::record_kind_t kind,
    input  encoder_pkg::angle_t angle,
    input  encoder_pkg::speed_t speed,
    input  stream_pkg::destination_t destination,
    output stream_pkg::record_data_t record_data,
    output stream_pkg::destination_t record_dest,
    output stream_pkg::record_kind_t record_kind,
    output logic record_valid
);

    import encoder_pkg::*;
    import stream_pkg::*;

    localparam int pad_angle = $bits(record_data_t) - $bits(angle_t);
    localparam int pad_speed = $bits(record_data_t) - $bits(speed_t);

    record_data_t selected;

    // The angle is unsigned and zero-extended, the speed keeps its sign
    always_comb begin
        if (kind == kind_angle) begin
            selected = {{pad_angle{1'b0}}, angle};
        end else begin
            selected = {{pad_speed{speed[$bits(speed_t)-1]}}, speed};
        end
    end

    // The angle is registered on the sample edge, so the record holds that value
    always_ff @(posedge clock) begin
        if (emit) begin
            record_data <= selected;
            record_dest <= destination;
            record_kind <= kind;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            record_valid <= 1'b0;
        end else begin
            record_valid <= emit;
        end
    end

endmodule

// File: source/angle_sensing.sv
// Incremental rotary encoder front end.
// Raw a, b and z may be asynchronous. Angle records and speed records go out
// on a valid-only stream with no back-pressure.
// max_count and output_destination are runtime inputs and may change at any
// time; a lower max_count clears an out-of-range angle.
module angle_sensing #(
    parameter int filter_length = 4,
    parameter int window_length = 256
) (
    input  logic clock,
    input  logic reset,
    input  logic a,
    input  logic b,
    input  logic z,
    input  logic sample,
    input  encoder_pkg::angle_t max_count,
    input  stream_pkg::destination_t output_destination,
    output encoder_pkg::angle_t angle_out,
    output encoder_pkg::speed_t speed_out,
    output encoder_pkg::index_state_t index_state,
    output encoder_pkg::error_count_t error_count,
    output stream_pkg::record_data_t record_data,
    output stream_pkg::destination_t record_dest,
    output stream_pkg::record_kind_t record_kind,
    output logic record_valid
);

    import stream_pkg::*;

    logic a_clean;
    logic b_clean;
    logic z_clean;
    logic step;
    logic direction;
    logic index_rise;
    logic capture_zero;
    logic load_zero;
    logic emit;
    record_kind_t kind;

    // Pin conditioning
    quadrature_filter #(
        .filter_length(filter_length)
    ) filter (
        .clock(clock),
        .reset(reset),
        .a(a),
        .b(b),
        .z(z),
        .a_clean(a_clean),
        .b_clean(b_clean),
        .z_clean(z_clean)
    );

    quadrature_decoder decoder (
        .clock(clock),
        .reset(reset),
        .a_clean(a_clean),
        .b_clean(b_clean),
        .z_clean(z_clean),
        .step(step),
        .direction(direction),
        .index_rise(index_rise),
        .error_count(error_count)
    );

    // Angle and speed datapath
    position_counter counter (
        .clock(clock),
        .reset(reset),
        .step(step),
        .direction(direction),
        .capture_zero(capture_zero),
        .load_zero(load_zero),
        .max_count(max_count),
        .angle(angle_out)
    );

    speed_estimator #(
        .window_length(window_length)
    ) estimator (
        .clock(clock),
        .reset(reset),
        .step(step),
        .direction(direction),
        .speed(speed_out)
    );

    // Zeroing control and record output
    index_control control (
        .clock(clock),
        .reset(reset),
        .index_rise(index_rise),
        .sample(sample),
        .capture_zero(capture_zero),
        .load_zero(load_zero),
        .index_state(index_state),
        .emit(emit),
        .kind(kind)
    );

    sample_output output_stage (
        .clock(clock),
        .reset(reset),
        .emit(emit),
        .kind(kind),
        .angle(angle_out),
        .speed(speed_out),
        .destination(output_destination),
        .record_data(record_data),
        .record_dest(record_dest),
        .record_kind(record_kind),
        .record_valid(record_valid)
    );

endmodule

// File: testbench/angle_sensing_tb.sv
// Directed testbench for the rotary encoder front end.
// Runs with filter_length 4 and window_length 256, and keeps max_count at 9
// once the first test sets it. Each encoder level is held 20 cycles, long
// enough for the filter, decoder and counter to settle before any check.
module angle_sensing_tb;

    import encoder_pkg::*;
    import stream_pkg::*;

    localparam int filter_length = 4;
    localparam int window_length = 256;
    localparam int hold_cycles = 20;
    localparam int glitch_cycles = 3;
    localparam int speed_steps = 32;
    localparam int record_watch = 6;
    // Two full windows without motion bring the latched speed back to 0
    localparam int idle_cycles = 2 * window_length + 64;
    // One step every hold_cycles gives this many steps per window after rounding
    localparam speed_t expected_speed = speed_t'((window_length + hold_cycles / 2) / hold_cycles);

    // The watchdog allows twice the sum of these per-test cycle budgets
    localparam int counting_budget = (12 + 15 + 2) * hold_cycles;
    localparam int index_budget = (3 * 2 + 5 + 2) * hold_cycles;
    localparam int glitch_budget = 3 * (1 + glitch_cycles + hold_cycles) + hold_cycles;
    localparam int illegal_budget = 2 * 2 * hold_cycles;
    localparam int record_budget = idle_cycles + record_watch + 10;
    localparam int speed_budget = 2 * (speed_steps * hold_cycles + record_watch + 10);
    localparam int timeout_cycles = 2 * (2 + counting_budget + index_budget + glitch_budget
        + illegal_budget + record_budget + speed_budget);

    logic clock, reset, a, b, z, sample;
    angle_t max_count, angle_out;
    destination_t output_destination, record_dest;
    speed_t speed_out;
    index_state_t index_state;
    error_count_t error_count;
    record_data_t record_data;
    record_kind_t record_kind;
    logic record_valid;

    // Software reference state
    angle_t model_angle, zero_angle, model_limit;
    error_count_t model_errors;
    destination_t dest;
    int phase;
    logic [31:0] lfsr_state;

    // Bookkeeping for the report
    string test_name;
    int failures, checks, tests_run, tests_failed, failures_at_start, cycle_count;

    // Records seen after a sample
    record_data_t got_data [2];
    destination_t got_dest [2];
    record_kind_t got_kind [2];
    int valid_cycle [2];
    int valid_count;

    angle_sensing #(
        .filter_length(filter_length),
        .window_length(window_length)
    ) DUT (
        .clock(clock), .reset(reset), .a(a), .b(b), .z(z), .sample(sample),
        .max_count(max_count), .output_destination(output_destination),
        .angle_out(angle_out), .speed_out(speed_out), .index_state(index_state),
        .error_count(error_count), .record_data(record_data), .record_dest(record_dest),
        .record_kind(record_kind), .record_valid(record_valid)
    );

    always #5 clock = ~clock;

    // Galois LFSR stepped once for every random bit
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return (state >> 1) ^ (state[0] ? 32'h8020_0003 : 32'h0);
    endfunction

    function automatic logic [31:0] random_word();
        logic [31:0] word;
        for (int i = 0; i < 32; i++) begin
            word[i] = lfsr_state[0];
            lfsr_state = lfsr_next(lfsr_state);
        end
        return word;
    endfunction

    // Counter wrap rule where 0 and the limit are neighbours
    function automatic angle_t wrap_step(input angle_t count, input logic up, input angle_t limit);
        if (up) begin
            return (count == limit) ? '0 : count + 1'b1;
        end
        return (count == '0) ? limit : count - 1'b1;
    endfunction

    // Gray sequence as {a, b} where the forward order counts up
    function automatic logic [1:0] gray_levels(input int p);
        case (p)
            0: return 2'b00;
            1: return 2'b10;
            2: return 2'b11;
            default: return 2'b01;
        endcase
    endfunction

    task automatic check_angle(input angle_t actual, input angle_t expected);
        checks++;
        if (actual !== expected) begin
            failures++;
            $display("FAILED %s: angle expected %0d, actual %0d", test_name, expected, actual);
        end
    endtask

    task automatic check_speed(input speed_t actual, input speed_t expected);
        int diff;
        diff = int'(actual) - int'(expected);
        checks++;
        if (diff > 1 || diff < -1) begin
            failures++;
            $display("FAILED %s: speed expected %0d +/-1, actual %0d", test_name, expected, actual);
        end
    endtask

    task automatic check_state(input index_state_t actual, input index_state_t expected);
        checks++;
        if (actual !== expected) begin
            failures++;
            $display("FAILED %s: index state expected %s, actual %s", test_name,
                expected.name(), actual.name());
        end
    endtask

    task automatic check_errors(input error_count_t actual, input error_count_t expected);
        checks++;
        if (actual !== expected) begin
            failures++;
            $display("FAILED %s: error count expected %0d, actual %0d", test_name, expected, actual);
        end
    endtask

    task automatic check_record(input int beat, input record_data_t data_expected,
        input record_kind_t kind_expected);
        checks++;
        if (got_data[beat] !== data_expected || got_dest[beat] !== dest
            || got_kind[beat] !== kind_expected) begin
            failures++;
            $display("FAILED %s: record %0d expected %h/%h/%s, actual %h/%h/%s", test_name, beat,
                data_expected, dest, kind_expected.name(), got_data[beat], got_dest[beat],
                got_kind[beat].name());
        end
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        failures_at_start = failures;
        tests_run++;
    endtask

    task automatic finish_test();
        if (failures == failures_at_start) begin
            $display("Test %s finished without errors", test_name);
        end else begin
            tests_failed++;
            $display("Test %s finished with %0d errors", test_name, failures - failures_at_start);
        end
    endtask

    // Walks a and b through the Gray sequence and holds each level
    task automatic move_steps(input int count, input logic up);
        logic [1:0] levels;
        for (int i = 0; i < count; i++) begin
            phase = up ? (phase + 1) % 4 : (phase + 3) % 4;
            levels = gray_levels(phase);
            @(posedge clock);
            a <= levels[1];
            b <= levels[0];
            repeat (hold_cycles - 1) @(posedge clock);
            model_angle = wrap_step(model_angle, up, model_limit);
        end
    endtask

    task automatic pulse_index();
        @(posedge clock);
        z <= 1'b1;
        repeat (hold_cycles) @(posedge clock);
        z <= 1'b0;
        repeat (hold_cycles) @(posedge clock);
    endtask

    task automatic flip_pin(input int pin);
        case (pin)
            0: a <= ~a;
            1: b <= ~b;
            default: z <= ~z;
        endcase
    endtask

    // A pulse shorter than the filter needs must not move anything downstream
    // A pulse that slipped through would move the angle only for a few cycles,
    // which is why the whole hold is watched
    task automatic glitch_pin(input int pin);
        @(posedge clock);
        flip_pin(pin);
        repeat (glitch_cycles) @(posedge clock);
        flip_pin(pin);
        repeat (hold_cycles) begin
            @(negedge clock);
            check_angle(angle_out, model_angle);
            check_state(index_state, locked);
            check_errors(error_count, model_errors);
        end
    endtask

    // Sample pulse is high at one edge; records come on the following cycles
    task automatic take_sample();
        valid_count = 0;
        for (int i = 0; i < 2; i++) begin
            got_data[i] = '0;
            got_dest[i] = '0;
            got_kind[i] = kind_angle;
            valid_cycle[i] = -1;
        end
        @(posedge clock);
        sample <= 1'b1;
        @(posedge clock);
        sample <= 1'b0;
        for (int cycle = 0; cycle < record_watch; cycle++) begin
            @(negedge clock);
            if (record_valid) begin
                if (valid_count < 2) begin
                    got_data[valid_count] = record_data;
                    got_dest[valid_count] = record_dest;
                    got_kind[valid_count] = record_kind;
                    valid_cycle[valid_count] = cycle;
                end
                valid_count++;
            end
        end
        checks++;
        if (valid_count != 2 || valid_cycle[0] != 0 || valid_cycle[1] != 1) begin
            failures++;
            $display("%s: expected two valid records on the two cycles after the sample, saw %0d",
                test_name, valid_count);
        end
    endtask

    task automatic test_counting();
        begin_test("counting_wrap");
        @(negedge clock);
        check_angle(angle_out, '0);
        check_state(index_state, seek_first);
        model_limit = 24'd9;
        @(posedge clock);
        max_count <= model_limit;
        move_steps(12, 1'b1);
        @(negedge clock);
        check_angle(angle_out, model_angle);
        move_steps(15, 1'b0);
        @(negedge clock);
        check_angle(angle_out, model_angle);
        finish_test();
    endtask

    task automatic test_index();
        begin_test("index_zeroing");
        // First edge only arms the zeroing
        pulse_index();
        @(negedge clock);
        check_angle(angle_out, model_angle);
        check_state(index_state, seek_second);
        pulse_index();
        zero_angle = model_angle;
        @(negedge clock);
        check_angle(angle_out, model_angle);
        check_state(index_state, locked);
        move_steps(5, 1'b1);
        @(negedge clock);
        check_angle(angle_out, model_angle);
        // Later edges reload the captured zero value
        pulse_index();
        model_angle = zero_angle;
        @(negedge clock);
        check_angle(angle_out, model_angle);
        check_state(index_state, locked);
        finish_test();
    endtask

    task automatic test_glitch();
        begin_test("glitch_rejection");
        // Move off the zero value so a false index reload shows on the angle
        move_steps(1, 1'b1);
        for (int pin = 0; pin < 3; pin++) begin
            glitch_pin(pin);
        end
        finish_test();
    endtask

    task automatic test_illegal();
        begin_test("illegal_transition");
        repeat (2) begin
            @(posedge clock);
            a <= ~a;
            b <= ~b;
            phase = (phase + 2) % 4;
            repeat (hold_cycles - 1) @(posedge clock);
            model_errors++;
            @(negedge clock);
            check_angle(angle_out, model_angle);
            check_errors(error_count, model_errors);
        end
        finish_test();
    endtask

    task automatic test_records();
        begin_test("sample_records");
        dest = random_word();
        @(posedge clock);
        output_destination <= dest;
        // Two windows without motion leave a speed of 0
        repeat (idle_cycles) @(posedge clock);
        @(negedge clock);
        check_speed(speed_out, '0);
        take_sample();
        check_record(0, record_data_t'(model_angle), kind_angle);
        check_record(1, '0, kind_speed);
        finish_test();
    endtask

    task automatic test_speed();
        begin_test("speed_window");
        move_steps(speed_steps, 1'b1);
        @(negedge clock);
        check_speed(speed_out, expected_speed);
        take_sample();
        check_record(0, record_data_t'(model_angle), kind_angle);
        check_speed(speed_t'(got_data[1][15:0]), expected_speed);
        // A positive speed is extended with zeros
        check_record(1, {16'h0000, got_data[1][15:0]}, kind_speed);
        move_steps(speed_steps, 1'b0);
        @(negedge clock);
        check_speed(speed_out, -expected_speed);
        take_sample();
        check_record(0, record_data_t'(model_angle), kind_angle);
        check_speed(speed_t'(got_data[1][15:0]), -expected_speed);
        check_record(1, {16'hffff, got_data[1][15:0]}, kind_speed);
        finish_test();
    endtask

    // Watchdog on a cycle counter
    initial begin : watchdog
        cycle_count = 0;
        while (cycle_count < timeout_cycles) begin
            @(posedge clock);
            cycle_count++;
        end
        $display("Timeout after %0d cycles, the tests did not finish", cycle_count);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        clock = 1'b0;
        reset = 1'b1;
        a = 1'b0;
        b = 1'b0;
        z = 1'b0;
        sample = 1'b0;
        max_count = '0;
        output_destination = '0;
        lfsr_state = 32'hd95a37bb;
        model_angle = '0;
        zero_angle = '0;
        model_limit = '0;
        model_errors = '0;
        dest = '0;
        phase = 0;
        failures = 0;
        checks = 0;
        tests_run = 0;
        tests_failed = 0;
        repeat (2) @(posedge clock);
        reset <= 1'b0;
        test_counting();
        test_index();
        test_glitch();
        test_illegal();
        test_records();
        test_speed();
        $display("Tests %0d, tests failed %0d, checks %0d, check failures %0d",
            tests_run, tests_failed, checks, failures);
        if (failures == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: files.f
source/encoder_pkg.sv
source/stream_pkg.sv
source/quadrature_filter.sv
source/quadrature_decoder.sv
source/position_counter.sv
source/speed_estimator.sv
source/index_control.sv
source/sample_output.sv
source/angle_sensing.sv
testbench/angle_sensing_tb.sv

// File: Makefile
VERILATOR ?= verilator
VERILATOR_FLAGS = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing -Wall
TOP = angle_sensing_tb
RTL_TOP = angle_sensing
FILE_LIST = files.f
BUILD_DIR = obj_dir
LOG = sim.log
FAIL_TEXT = Simulation failed

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILE_LIST) $(shell cat $(FILE_LIST))
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILE_LIST)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "$(FAIL_TEXT)" >> $(LOG)
	cat $(LOG)
	@! grep -q "$(FAIL_TEXT)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILE_LIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
